// ==== dataMemorySubsystem.f ====
memAccessPkg.sv
memoryBank.sv
storeFormatter.sv
loadFormatter.sv
apbMemSlave.sv
dataMemorySubsystem.sv
dataMemorySubsystem_assertions.sv
dataMemorySubsystemTb.sv

// ==== dataMemorySubsystemTb.sv ====
module dataMemorySubsystemTb
    import memAccessPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int addrWidth  = 10;
    localparam int depthWords = 1 << addrWidth;
    localparam int memBytes   = 4 * depthWords;
    localparam int numWords   = 16;

    // wordTest, byteTest, halfTest, errorTest, timingTest
    localparam int numTransfers = 2 * numWords + 18 + 7 + 8 + 6;
    localparam int watchdogNs   = 20 * numTransfers * 3 * 10;

    logic     Clock;
    logic     rstN;
    logic     psel;
    logic     penable;
    logic     pwrite;
    byteAddrT paddr;
    wordT     pwdata;
    wordT     prdata;
    logic     pready;
    logic     pslverr;
    sizeCodeT accessSize;

    // Byte-wide model, one entry per byte address
    logic [7:0] refMem [byteAddrT];

    int errorCount = 0;
    int checkCount = 0;
    int testCount  = 0;

    dataMemorySubsystem #(
        .addrWidth (addrWidth)
    ) u_dataMemorySubsystem (
        .Clock      (Clock),
        .rstN       (rstN),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .accessSize (accessSize)
    );

    always #5 Clock = ~Clock;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] getByte(input byteAddrT addr);
        return refMem.exists(addr) ? refMem[addr] : 8'h00;
    endfunction

    // Big-endian, lowest address holds the most significant byte
    function automatic void modelWrite(input byteAddrT addr, input wordT data,
                                       input sizeCodeT size);
        if (size == sizeWord) begin
            refMem[addr]     = data[31:24];
            refMem[addr + 1] = data[23:16];
            refMem[addr + 2] = data[15:8];
            refMem[addr + 3] = data[7:0];
        end else if (size == sizeHalf) begin
            refMem[addr]     = data[15:8];
            refMem[addr + 1] = data[7:0];
        end else begin
            refMem[addr] = data[7:0];
        end
    endfunction

    function automatic wordT modelRead(input byteAddrT addr, input sizeCodeT size);
        if (size == sizeWord) begin
            return {getByte(addr), getByte(addr + 1), getByte(addr + 2), getByte(addr + 3)};
        end else if (size == sizeHalf) begin
            return {16'h0000, getByte(addr), getByte(addr + 1)};
        end
        return {24'h000000, getByte(addr)};
    endfunction

    function automatic logic illegalAccess(input byteAddrT addr, input sizeCodeT size);
        logic bad;
        bad = (addr >= byteAddrT'(memBytes));
        if (size == sizeReserved) begin
            bad = 1'b1;
        end
        if (size == sizeWord && addr[1:0] != 2'b00) begin
            bad = 1'b1;
        end
        if (size == sizeHalf && addr[0]) begin
            bad = 1'b1;
        end
        return bad;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////////////////////

    // Returns after the negedge that sees pready, so a following call starts
    // its setup on the completing edge with no idle cycle
    task automatic runTransfer(input logic write, input byteAddrT addr, input wordT data,
                               input sizeCodeT size, output wordT rdata, output logic err,
                               output int cycles);
        int waitCount;
        waitCount = 0;
        @(posedge Clock);
        psel       <= 1'b1;
        penable    <= 1'b0;
        pwrite     <= write;
        paddr      <= addr;
        pwdata     <= data;
        accessSize <= size;
        cycles = 1;
        @(posedge Clock);
        penable <= 1'b1;
        cycles = 2;
        @(negedge Clock);
        while (!pready && waitCount < 8) begin
            @(posedge Clock);
            cycles++;
            waitCount++;
            @(negedge Clock);
        end
        if (!pready) begin
            $display("ERROR at %0t: slave never raised pready for address 0x%08h", $time, addr);
            errorCount++;
        end
        rdata = prdata;
        err   = pslverr;
    endtask

    task automatic idleBus();
        @(posedge Clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic accessCheck(input logic write, input byteAddrT addr, input wordT data,
                               input sizeCodeT size);
        wordT rdata;
        wordT expData;
        logic err;
        logic expErr;
        int   cycles;
        int   expCycles;
        expErr    = illegalAccess(addr, size);
        expData   = (!write && !expErr) ? modelRead(addr, size) : '0;
        expCycles = (write || expErr) ? 2 : 3;
        runTransfer(write, addr, data, size, rdata, err, cycles);
        checkCount++;
        if (err !== expErr) begin
            $display("MISMATCH at %0t: addr 0x%08h size %0d pslverr %0b expected %0b",
                     $time, addr, size, err, expErr);
            errorCount++;
        end
        if (rdata !== expData) begin
            $display("MISMATCH at %0t: addr 0x%08h size %0d prdata 0x%08h expected 0x%08h",
                     $time, addr, size, rdata, expData);
            errorCount++;
        end
        if (cycles != expCycles) begin
            $display("MISMATCH at %0t: addr 0x%08h took %0d cycles, expected %0d",
                     $time, addr, cycles, expCycles);
            errorCount++;
        end
        if (write && !expErr) begin
            modelWrite(addr, data, size);
        end
    endtask

    function automatic byteAddrT randomWordAddr();
        return byteAddrT'($urandom_range(depthWords - 1, 0)) << 2;
    endfunction

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        $display("Test %s done with %0d errors", name, errorCount - startErrors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic wordTest();
        byteAddrT addrList [numWords];
        int       startErrors;
        startErrors = errorCount;
        for (int i = 0; i < numWords; i++) begin
            addrList[i] = randomWordAddr();
            accessCheck(1'b1, addrList[i], $urandom(), sizeWord);
        end
        for (int i = 0; i < numWords; i++) begin
            accessCheck(1'b0, addrList[i], '0, sizeWord);
        end
        idleBus();
        reportTest("word", startErrors);
    endtask

    task automatic byteTest();
        byteAddrT base;
        int       startErrors;
        startErrors = errorCount;
        for (int w = 0; w < 2; w++) begin
            base = randomWordAddr();
            for (int off = 0; off < 4; off++) begin
                accessCheck(1'b1, base + off, $urandom(), sizeByte);
            end
            accessCheck(1'b0, base, '0, sizeWord);
            for (int off = 0; off < 4; off++) begin
                accessCheck(1'b0, base + off, '0, sizeByte);
            end
        end
        idleBus();
        reportTest("byte", startErrors);
    endtask

    task automatic halfTest();
        byteAddrT base;
        int       startErrors;
        startErrors = errorCount;
        base = randomWordAddr();
        // Full word first so the untouched half has known contents
        accessCheck(1'b1, base, $urandom(), sizeWord);
        accessCheck(1'b1, base, $urandom(), sizeHalf);
        accessCheck(1'b0, base, '0, sizeWord);
        accessCheck(1'b0, base, '0, sizeHalf);
        accessCheck(1'b0, base + 2, '0, sizeHalf);
        accessCheck(1'b1, base + 2, $urandom(), sizeHalf);
        accessCheck(1'b0, base, '0, sizeWord);
        idleBus();
        reportTest("half", startErrors);
    endtask

    task automatic errorTest();
        byteAddrT base;
        int       startErrors;
        startErrors = errorCount;
        base = randomWordAddr();
        accessCheck(1'b1, base, $urandom(), sizeWord);
        accessCheck(1'b1, base + 1, $urandom(), sizeHalf);
        accessCheck(1'b1, base + 2, $urandom(), sizeWord);
        accessCheck(1'b1, base, $urandom(), sizeReserved);
        accessCheck(1'b1, base + byteAddrT'(memBytes), $urandom(), sizeWord);
        accessCheck(1'b0, base | 32'h8000_0000, '0, sizeWord);
        accessCheck(1'b0, base + 1, '0, sizeWord);
        // Contents must be what the first write left
        accessCheck(1'b0, base, '0, sizeWord);
        idleBus();
        reportTest("error", startErrors);
    endtask

    task automatic timingTest();
        int startErrors;
        startErrors = errorCount;
        // No idle cycles, lowest and highest word
        accessCheck(1'b1, 32'h0000_0000, $urandom(), sizeWord);
        accessCheck(1'b1, byteAddrT'(memBytes - 4), $urandom(), sizeWord);
        accessCheck(1'b0, 32'h0000_0000, '0, sizeWord);
        accessCheck(1'b0, byteAddrT'(memBytes - 4), '0, sizeWord);
        accessCheck(1'b1, 32'h0000_0003, $urandom(), sizeByte);
        accessCheck(1'b0, 32'h0000_0000, '0, sizeWord);
        idleBus();
        reportTest("timing", startErrors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int totalErrors;
        void'($urandom(32'h6601_5fdd));
        Clock      = 1'b0;
        rstN       = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        accessSize = sizeWord;
        repeat (10) @(posedge Clock);
        rstN <= 1'b1;
        wordTest();
        byteTest();
        halfTest();
        errorTest();
        timingTest();
        totalErrors = errorCount
                    + u_dataMemorySubsystem.u_apbMemSlave.u_apbProtocolAssertions.failCount;
        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, totalErrors);
        if (totalErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns, the tests did not complete", watchdogNs);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== dataMemorySubsystem_assertions.sv ====
module apbProtocolAssertions
    import memAccessPkg::*;
(
    input logic     Clock,
    input logic     rstN,
    input apbStateT state,
    input logic     pready,
    input logic     pslverr,
    input logic     writeStrobe
);

    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    ////////////////////////////////////////////////////////////////////////////
    // APB slave protocol
    ////////////////////////////////////////////////////////////////////////////

    // No completion while idle
    idleNoReady: assert property (@(posedge Clock) disable iff (!rstN)
        (state == stIdle) |-> !pready)
    else begin
        $error("pready high while the slave FSM is idle");
        failCount++;
    end

    errorWithReady: assert property (@(posedge Clock) disable iff (!rstN)
        pslverr |-> pready)
    else begin
        $error("pslverr high without pready");
        failCount++;
    end

    // A failed access must not write the banks
    noWriteOnError: assert property (@(posedge Clock) disable iff (!rstN)
        $rose(writeStrobe) |-> !pslverr)
    else begin
        $error("writeStrobe rose together with pslverr");
        failCount++;
    end

endmodule

bind apbMemSlave apbProtocolAssertions u_apbProtocolAssertions (
    .Clock       (Clock),
    .rstN        (rstN),
    .state       (state),
    .pready      (pready),
    .pslverr     (pslverr),
    .writeStrobe (writeStrobe)
);

// ==== dataMemorySubsystem.sv ====
module dataMemorySubsystem
    import memAccessPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic     Clock,
    input  logic     rstN,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  byteAddrT paddr,
    input  wordT     pwdata,
    output wordT     prdata,
    output logic     pready,
    output logic     pslverr,
    input  sizeCodeT accessSize
);

    logic [addrWidth-1:0] wordIndex;
    offsetT               byteOffset;
    sizeCodeT             storeSize;
    wordT                 storeData;
    logic                 writeStrobe;
    logic                 readEnable;
    loadSelT              loadSel;
    laneMaskT             upperLanes;
    laneMaskT             lowerLanes;
    halfT                 upperWrData;
    halfT                 lowerWrData;
    halfT                 upperRdData;
    halfT                 lowerRdData;
    wordT                 loadData;

    ////////////////////////////////////////////////////////////////////////////
    // APB slave and store path
    ////////////////////////////////////////////////////////////////////////////

    apbMemSlave #(
        .addrWidth (addrWidth)
    ) u_apbMemSlave (
        .Clock       (Clock),
        .rstN        (rstN),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .accessSize  (accessSize),
        .loadData    (loadData),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .wordIndex   (wordIndex),
        .byteOffset  (byteOffset),
        .storeSize   (storeSize),
        .storeData   (storeData),
        .writeStrobe (writeStrobe),
        .readEnable  (readEnable),
        .loadSel     (loadSel)
    );

    storeFormatter u_storeFormatter (
        .storeSize   (storeSize),
        .byteOffset  (byteOffset),
        .storeData   (storeData),
        .upperLanes  (upperLanes),
        .lowerLanes  (lowerLanes),
        .upperWrData (upperWrData),
        .lowerWrData (lowerWrData)
    );

    // Bits 31..16
    memoryBank #(
        .addrWidth (addrWidth)
    ) upperBank (
        .Clock       (Clock),
        .writeStrobe (writeStrobe),
        .laneEnable  (upperLanes),
        .bankIndex   (wordIndex),
        .writeData   (upperWrData),
        .readEnable  (readEnable),
        .readData    (upperRdData)
    );

    // Bits 15..0
    memoryBank #(
        .addrWidth (addrWidth)
    ) lowerBank (
        .Clock       (Clock),
        .writeStrobe (writeStrobe),
        .laneEnable  (lowerLanes),
        .bankIndex   (wordIndex),
        .writeData   (lowerWrData),
        .readEnable  (readEnable),
        .readData    (lowerRdData)
    );

    loadFormatter u_loadFormatter (
        .loadSel     (loadSel),
        .upperRdData (upperRdData),
        .lowerRdData (lowerRdData),
        .loadData    (loadData)
    );

endmodule

// ==== apbMemSlave.sv ====
module apbMemSlave
    import memAccessPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  byteAddrT             paddr,
    input  wordT                 pwdata,
    input  sizeCodeT             accessSize,
    input  wordT                 loadData,
    output wordT                 prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic [addrWidth-1:0] wordIndex,
    output offsetT               byteOffset,
    output sizeCodeT             storeSize,
    output wordT                 storeData,
    output logic                 writeStrobe,
    output logic                 readEnable,
    output loadSelT              loadSel
);

    apbStateT state;
    apbStateT nextState;
    logic     accessCycle;
    logic     sizeError;
    logic     alignError;
    logic     rangeError;
    logic     accessError;

    // Address split, master holds these stable through the access
    assign wordIndex  = paddr[addrWidth+1:2];
    assign byteOffset = paddr[1:0];
    assign storeSize  = accessSize;
    assign storeData  = pwdata;

    ////////////////////////////////////////////////////////////////////////////
    // Access checks
    ////////////////////////////////////////////////////////////////////////////

    assign sizeError = (accessSize == sizeReserved);

    always_comb begin
        case (accessSize)
            sizeWord: alignError = (paddr[1:0] != 2'b00);
            sizeHalf: alignError = paddr[0];
            default:  alignError = 1'b0;
        endcase
    end

    // Any address bit above the word index is out of range
    assign rangeError  = ((paddr >> (addrWidth + 2)) != '0);
    assign accessError = sizeError | alignError | rangeError;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (psel && !penable) begin
                    nextState = stAccess;
                end
            end
            stAccess: begin
                // Writes and errors complete here, reads wait for the banks
                if (accessCycle) begin
                    if (pwrite || accessError) begin
                        nextState = stIdle;
                    end else begin
                        nextState = stReadWait;
                    end
                end
            end
            stReadWait: nextState = stIdle;
            default:    nextState = stIdle;
        endcase
    end

    assign accessCycle = (state == stAccess) && psel && penable;
    assign writeStrobe = accessCycle && pwrite && !accessError;
    assign readEnable  = accessCycle && !pwrite && !accessError;
    assign pslverr     = accessCycle && accessError;
    assign pready      = (accessCycle && (pwrite || accessError)) || (state == stReadWait);

    // Bank data is valid only in the wait state
    assign prdata = (state == stReadWait) ? loadData : '0;

    // Size and offset held for the load formatter
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            loadSel <= '0;
        end else if (readEnable) begin
            loadSel <= {accessSize, paddr[1:0]};
        end
    end

endmodule

// ==== loadFormatter.sv ====
module loadFormatter
    import memAccessPkg::*;
(
    input  loadSelT loadSel,
    input  halfT    upperRdData,
    input  halfT    lowerRdData,
    output wordT    loadData
);

    sizeCodeT loadSize;
    offsetT   loadOffset;
    logic [7:0] selByte;

    assign loadSize   = loadSel[3:2];
    assign loadOffset = loadSel[1:0];

    // Big-endian byte pick, offset 0 is the upper bank high byte
    always_comb begin
        case (loadOffset)
            2'd0:    selByte = upperRdData[15:8];
            2'd1:    selByte = upperRdData[7:0];
            2'd2:    selByte = lowerRdData[15:8];
            default: selByte = lowerRdData[7:0];
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result with zero extension
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (loadSize)
            sizeWord: begin
                loadData = {upperRdData, lowerRdData};
            end
            sizeHalf: begin
                if (loadOffset[1]) begin
                    loadData = {16'h0000, lowerRdData};
                end else begin
                    loadData = {16'h0000, upperRdData};
                end
            end
            sizeByte: begin
                loadData = {24'h000000, selByte};
            end
            default: begin
                loadData = '0;
            end
        endcase
    end

endmodule

// ==== storeFormatter.sv ====
module storeFormatter
    import memAccessPkg::*;
(
    input  sizeCodeT storeSize,
    input  offsetT   byteOffset,
    input  wordT     storeData,
    output laneMaskT upperLanes,
    output laneMaskT lowerLanes,
    output halfT     upperWrData,
    output halfT     lowerWrData
);

    always_comb begin
        upperLanes  = 2'b00;
        lowerLanes  = 2'b00;
        upperWrData = storeData[31:16];
        lowerWrData = storeData[15:0];
        case (storeSize)
            sizeWord: begin
                upperLanes = 2'b11;
                lowerLanes = 2'b11;
            end
            sizeHalf: begin
                // Low 16 data bits go to whichever bank the offset selects
                upperWrData = storeData[15:0];
                lowerWrData = storeData[15:0];
                if (byteOffset[1]) begin
                    lowerLanes = 2'b11;
                end else begin
                    upperLanes = 2'b11;
                end
            end
            sizeByte: begin
                upperWrData = {storeData[7:0], storeData[7:0]};
                lowerWrData = {storeData[7:0], storeData[7:0]};
                case (byteOffset)
                    2'd0:    upperLanes = 2'b10;
                    2'd1:    upperLanes = 2'b01;
                    2'd2:    lowerLanes = 2'b10;
                    default: lowerLanes = 2'b01;
                endcase
            end
            default: begin
                // Reserved size writes nothing
                upperLanes = 2'b00;
                lowerLanes = 2'b00;
            end
        endcase
    end

endmodule

// ==== memoryBank.sv ====
module memoryBank
    import memAccessPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic                 Clock,
    input  logic                 writeStrobe,
    input  laneMaskT             laneEnable,
    input  logic [addrWidth-1:0] bankIndex,
    input  halfT                 writeData,
    input  logic                 readEnable,
    output halfT                 readData
);

    localparam int depth = 1 << addrWidth;

    halfT memArray [depth];

    ////////////////////////////////////////////////////////////////////////////
    // Byte lane writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clock) begin
        if (writeStrobe && laneEnable[1]) begin
            memArray[bankIndex][15:8] <= writeData[15:8];
        end
        if (writeStrobe && laneEnable[0]) begin
            memArray[bankIndex][7:0] <= writeData[7:0];
        end
    end

    // Registered read, holds its value between reads
    always_ff @(posedge Clock) begin
        if (readEnable) begin
            readData <= memArray[bankIndex];
        end
    end

endmodule

// ==== memAccessPkg.sv ====
package memAccessPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data and address widths
    ////////////////////////////////////////////////////////////////////////////

    // Full APB data word
    typedef logic [31:0] wordT;

    // One bank's data, bits 31..16 or 15..0 of a word
    typedef logic [15:0] halfT;

    // APB byte address
    typedef logic [31:0] byteAddrT;

    // Byte lane enables of one bank, bit 1 is the high byte
    typedef logic [1:0] laneMaskT;

    // Byte offset inside a word, 0 is bits 31..24
    typedef logic [1:0] offsetT;

    ////////////////////////////////////////////////////////////////////////////
    // Access size
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [1:0] sizeCodeT;

    localparam sizeCodeT sizeWord     = 2'd0;
    localparam sizeCodeT sizeHalf     = 2'd1;
    localparam sizeCodeT sizeByte     = 2'd2;
    localparam sizeCodeT sizeReserved = 2'd3;

    // Registered load select, size in bits 3..2 and offset in bits 1..0
    typedef logic [3:0] loadSelT;

    // APB slave FSM
    typedef enum logic [1:0] {
        stIdle,
        stAccess,
        stReadWait
    } apbStateT;

endpackage
